// File: Bender.yml
package:
  name: gmii_rx

sources:
  - files:
      - source/gmii_rx_pkg.sv
      - source/rx_front.sv
      - source/frame_capture.sv
      - source/frame_ram.sv
      - source/frame_drain.sv
      - source/crc32_check.sv
      - source/gmii_rx_top.sv
  - target: simulation
    files:
      - tb/gmii_rx_props.sv
      - tb/tb_gmii_rx.sv

// File: flist.f
source/gmii_rx_pkg.sv
source/rx_front.sv
source/frame_capture.sv
source/frame_ram.sv
source/frame_drain.sv
source/crc32_check.sv
source/gmii_rx_top.sv
tb/gmii_rx_props.sv
tb/tb_gmii_rx.sv

// File: source/crc32_check.sv
module crc32_check (
  input  logic       rx_clk,
  input  logic       rstn_mac,
  input  logic       init,
  input  logic       byte_strb,
  input  logic [7:0] data,
  output logic       crc_ok
);

  logic [31:0] crc_q;

  // msb-first register fed lsb first as on the wire
  function automatic logic [31:0] crc_next(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0};
      if (fb) begin
        r = r ^ gmii_rx_pkg::CRC_POLY;
      end
    end
    return r;
  endfunction

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      crc_q <= '1;
    end else if (init) begin
      crc_q <= '1;      // preset to all ones
    end else if (byte_strb) begin
      crc_q <= crc_next(crc_q, data);
    end
  end

  // residue over data plus FCS
  assign crc_ok = (crc_q == gmii_rx_pkg::CRC_RESIDUE);

endmodule

// File: source/frame_capture.sv
module frame_capture (
  input  logic                           rx_clk,
  input  logic                           rstn_mac,
  input  logic                           q_dv,
  input  logic [7:0]                     q_data,
  input  logic                           sfd_hit,
  input  logic [gmii_rx_pkg::LEN_W-1:0]  idx,
  output logic                           ram_we,
  output logic [gmii_rx_pkg::ADDR_W-1:0] ram_waddr,
  output logic [7:0]                     ram_wdata,
  output logic                           start_strb,
  output gmii_rx_pkg::rx_class_e         start_class,
  output logic                           end_strb,
  output gmii_rx_pkg::frame_end_t        frame_end
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HUNT,    // in preamble
    ST_BODY,    // writing the frame
    ST_TAIL     // wait for rx_dv to drop
  } cap_state_e;

  cap_state_e state;
  logic       tag_wr;
  logic       frame_done;

  // ====================
  // RAM write port
  // ====================
  assign ram_we    = (state == ST_BODY) & q_dv & (idx < gmii_rx_pkg::CAP_LEN);
  assign ram_waddr = idx[gmii_rx_pkg::ADDR_W-1:0];
  assign ram_wdata = q_data;

  assign tag_wr     = ram_we & (idx == gmii_rx_pkg::TTE_TAG_IDX);
  assign frame_done = (state == ST_BODY) & (~q_dv | (idx == gmii_rx_pkg::CAP_LEN));

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      state      <= ST_IDLE;
      start_strb <= 1'b0;
      end_strb   <= 1'b0;
    end else begin
      start_strb <= 1'b0;
      end_strb   <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (q_dv) begin
            if (sfd_hit) begin
              state <= ST_BODY;   // no preamble at all
            end else if (q_data == gmii_rx_pkg::PREAMBLE_BYTE) begin
              state <= ST_HUNT;
            end else begin
              state <= ST_TAIL;
            end
          end
        end
        ST_HUNT: begin
          if (!q_dv) begin
            state <= ST_IDLE;
          end else if (sfd_hit) begin
            state <= ST_BODY;
          end else if (q_data != gmii_rx_pkg::PREAMBLE_BYTE) begin
            state <= ST_TAIL;     // junk in the preamble
          end
        end
        ST_BODY: begin
          if (tag_wr) begin
            start_strb <= 1'b1;
          end
          if (frame_done) begin
            // short frames never got a start and vanish here
            end_strb <= (idx > gmii_rx_pkg::TTE_TAG_IDX);
            state    <= q_dv ? ST_TAIL : ST_IDLE;
          end
        end
        default: begin
          if (!q_dv) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // class and length
  always_ff @(posedge rx_clk) begin
    if (tag_wr) begin
      start_class <= (q_data == gmii_rx_pkg::TTE_TAG) ? gmii_rx_pkg::RX_TTE
                                                      : gmii_rx_pkg::RX_BE;
    end
    if (frame_done) begin
      frame_end.len <= idx;   // bytes written so far
      frame_end.cls <= start_class;
    end
  end

endmodule

// File: source/frame_drain.sv
module frame_drain (
  input  logic                           rx_clk,
  input  logic                           rstn_mac,
  input  logic                           start_strb,
  input  gmii_rx_pkg::rx_class_e         start_class,
  input  logic                           end_strb,
  input  gmii_rx_pkg::frame_end_t        frame_end,
  input  logic [7:0]                     ram_rdata,
  input  logic                           crc_ok,
  output logic [gmii_rx_pkg::ADDR_W-1:0] ram_raddr,
  output logic                           crc_init,
  output logic                           crc_byte_strb,
  output logic [7:0]                     crc_byte,
  output logic                           byte_strb,
  output gmii_rx_pkg::rx_byte_t          byte_out,
  output logic                           desc_strb,
  output gmii_rx_pkg::rx_desc_t          desc
);

  logic                          busy;        // issuing reads
  logic                          len_known;
  logic [gmii_rx_pkg::LEN_W-1:0] rd_cnt;
  logic                          last_issue;
  logic                          rd_v;        // ram_rdata valid
  logic                          rd_last;
  logic                          fin;
  gmii_rx_pkg::frame_end_t       end_q;
  gmii_rx_pkg::rx_class_e        cls_q;

  // ====================
  // read side
  // ====================
  // reader trails the writer by 13 bytes
  assign last_issue = busy & len_known & (rd_cnt == end_q.len - 1'b1);
  assign ram_raddr  = rd_cnt[gmii_rx_pkg::ADDR_W-1:0];

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      busy      <= 1'b0;
      len_known <= 1'b0;
      rd_cnt    <= '0;
      rd_v      <= 1'b0;
      rd_last   <= 1'b0;
      fin       <= 1'b0;
      desc_strb <= 1'b0;
    end else begin
      if (end_strb) begin
        len_known <= 1'b1;
      end
      if (start_strb) begin
        busy      <= 1'b1;
        len_known <= 1'b0;
        rd_cnt    <= '0;
      end else if (busy) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (last_issue) begin
          busy <= 1'b0;
        end
      end
      rd_v      <= busy;
      rd_last   <= last_issue;
      fin       <= rd_v & rd_last;    // crc register settles here
      desc_strb <= fin;
    end
  end

  always_ff @(posedge rx_clk) begin
    if (start_strb) begin
      cls_q <= start_class;
    end
    if (end_strb) begin
      end_q <= frame_end;
    end
  end

  // ====================
  // byte stream and CRC feed
  // ====================
  assign byte_strb     = rd_v;
  assign byte_out.data = ram_rdata;
  assign byte_out.cls  = cls_q;

  assign crc_init      = start_strb;
  assign crc_byte_strb = rd_v;
  assign crc_byte      = ram_rdata;

  // descriptor
  always_ff @(posedge rx_clk) begin
    if (fin) begin
      desc.crc_err <= ~crc_ok;
      desc.len_err <= (end_q.len < gmii_rx_pkg::MIN_LEN) |
                      (end_q.len > gmii_rx_pkg::MAX_LEN);
      desc.cls     <= end_q.cls;
      desc.len     <= end_q.len;
    end
  end

endmodule

// File: source/frame_ram.sv
module frame_ram (
  input  logic                           rx_clk,
  input  logic                           we,
  input  logic [gmii_rx_pkg::ADDR_W-1:0] waddr,
  input  logic [7:0]                     wdata,
  input  logic [gmii_rx_pkg::ADDR_W-1:0] raddr,
  output logic [7:0]                     rdata
);

  localparam int DEPTH = 2 ** gmii_rx_pkg::ADDR_W;

  logic [7:0] mem [DEPTH];

  // write port
  always_ff @(posedge rx_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port
  always_ff @(posedge rx_clk) begin
    rdata <= mem[raddr];
  end

endmodule

// File: source/gmii_rx_pkg.sv
package gmii_rx_pkg;

  // ====================
  // sizes
  // ====================
  localparam int ADDR_W = 11;       // 2 KB frame RAM
  localparam int LEN_W  = 13;       // byte index and length width

  // ====================
  // GMII framing
  // ====================
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // class tag sits at byte 12 counted from the first byte after the SFD
  localparam int         TTE_TAG_IDX = 12;
  localparam logic [7:0] TTE_TAG     = 8'h92;

  localparam int MIN_LEN = 64;      // with FCS
  localparam int MAX_LEN = 1518;
  localparam int CAP_LEN = 1519;    // capture stops here

  // ====================
  // CRC-32, IEEE 802.3
  // ====================
  localparam logic [31:0] CRC_POLY    = 32'h04C11DB7;
  localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;  // good frame incl. FCS

  typedef enum logic {
    RX_BE  = 1'b0,
    RX_TTE = 1'b1
  } rx_class_e;

  typedef struct packed {
    logic [7:0] data;
    rx_class_e  cls;
  } rx_byte_t;

  typedef struct packed {
    logic [LEN_W-1:0] len;          // bytes written to the RAM
    rx_class_e        cls;
  } frame_end_t;

  // class lands in bit 13
  typedef struct packed {
    logic             crc_err;
    logic             len_err;
    rx_class_e        cls;
    logic [LEN_W-1:0] len;
  } rx_desc_t;

endpackage

// File: source/gmii_rx_top.sv
module gmii_rx_top (
  input  logic                  rx_clk,
  input  logic                  rstn_mac,
  input  logic                  rx_dv,
  input  logic [7:0]            rx_d,
  output logic                  byte_strb,
  output gmii_rx_pkg::rx_byte_t byte_out,
  output logic                  desc_strb,
  output gmii_rx_pkg::rx_desc_t desc
);

  logic                           q_dv;
  logic [7:0]                     q_data;
  logic                           sfd_hit;
  logic [gmii_rx_pkg::LEN_W-1:0]  idx;

  logic                           ram_we;
  logic [gmii_rx_pkg::ADDR_W-1:0] ram_waddr;
  logic [7:0]                     ram_wdata;
  logic [gmii_rx_pkg::ADDR_W-1:0] ram_raddr;
  logic [7:0]                     ram_rdata;

  logic                           start_strb;
  gmii_rx_pkg::rx_class_e         start_class;
  logic                           end_strb;
  gmii_rx_pkg::frame_end_t        frame_end;

  logic                           crc_init;
  logic                           crc_byte_strb;
  logic [7:0]                     crc_byte;
  logic                           crc_ok;

  // ====================
  // write side
  // ====================
  rx_front u_rx_front (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .rx_dv    (rx_dv),
    .rx_d     (rx_d),
    .q_dv     (q_dv),
    .q_data   (q_data),
    .sfd_hit  (sfd_hit),
    .idx      (idx)
  );

  frame_capture u_frame_capture (
    .rx_clk      (rx_clk),
    .rstn_mac    (rstn_mac),
    .q_dv        (q_dv),
    .q_data      (q_data),
    .sfd_hit     (sfd_hit),
    .idx         (idx),
    .ram_we      (ram_we),
    .ram_waddr   (ram_waddr),
    .ram_wdata   (ram_wdata),
    .start_strb  (start_strb),
    .start_class (start_class),
    .end_strb    (end_strb),
    .frame_end   (frame_end)
  );

  frame_ram u_frame_ram (
    .rx_clk (rx_clk),
    .we     (ram_we),
    .waddr  (ram_waddr),
    .wdata  (ram_wdata),
    .raddr  (ram_raddr),
    .rdata  (ram_rdata)
  );

  // ====================
  // read side
  // ====================
  frame_drain u_frame_drain (
    .rx_clk        (rx_clk),
    .rstn_mac      (rstn_mac),
    .start_strb    (start_strb),
    .start_class   (start_class),
    .end_strb      (end_strb),
    .frame_end     (frame_end),
    .ram_rdata     (ram_rdata),
    .crc_ok        (crc_ok),
    .ram_raddr     (ram_raddr),
    .crc_init      (crc_init),
    .crc_byte_strb (crc_byte_strb),
    .crc_byte      (crc_byte),
    .byte_strb     (byte_strb),
    .byte_out      (byte_out),
    .desc_strb     (desc_strb),
    .desc          (desc)
  );

  crc32_check u_crc32_check (
    .rx_clk    (rx_clk),
    .rstn_mac  (rstn_mac),
    .init      (crc_init),
    .byte_strb (crc_byte_strb),
    .data      (crc_byte),
    .crc_ok    (crc_ok)
  );

endmodule

// File: source/rx_front.sv
module rx_front (
  input  logic                          rx_clk,
  input  logic                          rstn_mac,
  input  logic                          rx_dv,
  input  logic [7:0]                    rx_d,
  output logic                          q_dv,
  output logic [7:0]                    q_data,
  output logic                          sfd_hit,
  output logic [gmii_rx_pkg::LEN_W-1:0] idx
);

  logic in_frame;   // set from the SFD until rx_dv drops

  // ====================
  // pin register
  // ====================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      q_dv   <= 1'b0;
      q_data <= 8'h00;
    end else begin
      q_dv   <= rx_dv;
      q_data <= rx_d;
    end
  end

  // payload bytes equal to D5 must not restart the index
  assign sfd_hit = q_dv & ~in_frame & (q_data == gmii_rx_pkg::SFD_BYTE);

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      in_frame <= 1'b0;
    end else if (!q_dv) begin
      in_frame <= 1'b0;
    end else if (sfd_hit) begin
      in_frame <= 1'b1;
    end
  end

  // ====================
  // byte index
  // ====================
  // 0 on the first byte after the SFD
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      idx <= '0;
    end else if (sfd_hit) begin
      idx <= '0;
    end else if (idx != '1) begin
      idx <= idx + 1'b1;    // hold at max during long idle
    end
  end

endmodule

// File: tb/gmii_rx_props.sv
module gmii_rx_props (
  input logic                  rx_clk,
  input logic                  rstn_mac,
  input logic                  byte_strb,
  input logic                  desc_strb,
  input gmii_rx_pkg::rx_desc_t desc
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;   // read back by the testbench

  // ====================
  // strobe timing
  // ====================
  a_desc_after_last: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    $fell(byte_strb) |=> desc_strb)
    else begin
      $error("descriptor missing two cycles after the last byte strobe");
      fail_cnt++;
    end

  // every descriptor closes a byte run
  a_desc_has_bytes: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    desc_strb |-> $past(byte_strb, 2) && !$past(byte_strb, 1))
    else begin
      $error("descriptor without a byte run ending two cycles before");
      fail_cnt++;
    end

  // no restart between the last byte and its descriptor
  a_no_gap: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    $fell(byte_strb) |=> !byte_strb)
    else begin
      $error("byte strobe resumed before the descriptor");
      fail_cnt++;
    end

  // ====================
  // reset and limits
  // ====================
  a_quiet_in_reset: assert property (@(posedge rx_clk)
    !rstn_mac |-> !byte_strb && !desc_strb)
    else begin
      $error("strobe seen while in reset");
      fail_cnt++;
    end

  a_len_cap: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    desc_strb |-> desc.len <= gmii_rx_pkg::CAP_LEN)
    else begin
      $error("descriptor length above the capture limit");
      fail_cnt++;
    end

endmodule

// File: tb/tb_gmii_rx.sv
module tb_gmii_rx;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED         = 32'h94eb_4e8c;
  localparam logic [31:0] POLY_REFL    = 32'hEDB88320;
  localparam logic [31:0] GOOD_RESIDUE = 32'hDEBB20E3;  // reflected form before inversion
  // about 2400 cycles of frames and gaps, so twice that plus margin
  localparam int          TIMEOUT_CYC  = 5000;

  logic                  rx_clk;
  logic                  rstn_mac;
  logic                  rx_dv;
  logic [7:0]            rx_d;
  logic                  byte_strb;
  gmii_rx_pkg::rx_byte_t byte_out;
  logic                  desc_strb;
  gmii_rx_pkg::rx_desc_t desc;

  logic [7:0]            frm [$];       // frame under construction with its FCS
  gmii_rx_pkg::rx_byte_t exp_bytes [$];
  gmii_rx_pkg::rx_desc_t exp_desc [$];
  string                 exp_name [$];
  gmii_rx_pkg::rx_byte_t exp_b;
  gmii_rx_pkg::rx_desc_t exp_d;
  int                    errors = 0;
  int                    cycles = 0;

  gmii_rx_top u_dut (
    .rx_clk    (rx_clk),
    .rstn_mac  (rstn_mac),
    .rx_dv     (rx_dv),
    .rx_d      (rx_d),
    .byte_strb (byte_strb),
    .byte_out  (byte_out),
    .desc_strb (desc_strb),
    .desc      (desc)
  );

  bind gmii_rx_top gmii_rx_props u_props (.*);

  initial begin
    rx_clk = 1'b0;
    forever #2 rx_clk = ~rx_clk;
  end

  // ====================
  // reference model
  // ====================
  function automatic logic [31:0] crc_refl(input int n);
    logic [31:0] c;
    c = '1;
    for (int i = 0; i < n; i++) begin
      c = c ^ {24'h0, frm[i]};
      for (int k = 0; k < 8; k++) begin
        if (c[0]) begin
          c = (c >> 1) ^ POLY_REFL;
        end else begin
          c = c >> 1;
        end
      end
    end
    return c;
  endfunction

  task automatic append_fcs();
    logic [31:0] fcs;
    fcs = ~crc_refl(frm.size());
    for (int k = 0; k < 4; k++) begin
      frm.push_back(fcs[8*k +: 8]);   // lsb byte first on the wire
    end
  endtask

  task automatic refresh_fcs();
    for (int k = 0; k < 4; k++) begin
      void'(frm.pop_back());
    end
    append_fcs();
  endtask

  task automatic make_frame(input int n, input logic tte);
    frm.delete();
    for (int i = 0; i < n - 4; i++) begin
      frm.push_back(8'($urandom()));
    end
    if (n - 4 > gmii_rx_pkg::TTE_TAG_IDX) begin
      frm[gmii_rx_pkg::TTE_TAG_IDX] = tte ? gmii_rx_pkg::TTE_TAG : 8'h08;
    end
    append_fcs();
  endtask

  task automatic make_junk(input int n);
    logic [7:0] b;
    frm.delete();
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom());
      if (b == gmii_rx_pkg::SFD_BYTE) begin
        b = 8'h00;
      end
      frm.push_back(b);
    end
  endtask

  task automatic expect_frame(input string name);
    int                     n;
    gmii_rx_pkg::rx_class_e cls;
    gmii_rx_pkg::rx_byte_t  b;
    gmii_rx_pkg::rx_desc_t  d;
    n = (frm.size() > gmii_rx_pkg::CAP_LEN) ? gmii_rx_pkg::CAP_LEN : frm.size();
    if (n <= gmii_rx_pkg::TTE_TAG_IDX) begin
      return;   // dropped without a tag byte
    end
    cls = (frm[gmii_rx_pkg::TTE_TAG_IDX] == gmii_rx_pkg::TTE_TAG) ? gmii_rx_pkg::RX_TTE
                                                                  : gmii_rx_pkg::RX_BE;
    for (int i = 0; i < n; i++) begin
      b.data = frm[i];
      b.cls  = cls;
      exp_bytes.push_back(b);
    end
    d.crc_err = (crc_refl(n) != GOOD_RESIDUE);
    d.len_err = (n < gmii_rx_pkg::MIN_LEN) || (n > gmii_rx_pkg::MAX_LEN);
    d.cls     = cls;
    d.len     = n[gmii_rx_pkg::LEN_W-1:0];
    exp_desc.push_back(d);
    exp_name.push_back(name);
  endtask

  // ====================
  // GMII driver
  // ====================
  task automatic drive_byte(input logic dv, input logic [7:0] d);
    @(posedge rx_clk);
    #1;
    rx_dv = dv;
    rx_d  = d;
  endtask

  task automatic run_frame(input string name, input logic with_sfd, input int gap);
    if (with_sfd) begin
      expect_frame(name);
    end
    repeat (7) drive_byte(1'b1, gmii_rx_pkg::PREAMBLE_BYTE);
    if (with_sfd) begin
      drive_byte(1'b1, gmii_rx_pkg::SFD_BYTE);
    end
    foreach (frm[i]) begin
      drive_byte(1'b1, frm[i]);
    end
    repeat (gap) drive_byte(1'b0, 8'h00);
  endtask

  // ====================
  // scoreboard
  // ====================
  always @(negedge rx_clk) begin
    if (byte_strb) begin
      if (exp_bytes.size() == 0) begin
        $display("byte strobe seen with no frame expected");
        errors++;
      end else begin
        exp_b = exp_bytes.pop_front();
        assert (byte_out == exp_b) else begin
          $display("FAIL %s byte: expected %h actual %h", exp_name[0], exp_b, byte_out);
          errors++;
        end
      end
    end
    if (desc_strb) begin
      if (exp_desc.size() == 0) begin
        $display("descriptor seen with no frame expected");
        errors++;
      end else begin
        exp_d = exp_desc.pop_front();
        assert (desc == exp_d) else begin
          $display("FAIL %s desc: expected %h actual %h", exp_name[0], exp_d, desc);
          errors++;
        end
        void'(exp_name.pop_front());
      end
    end
  end

  always @(posedge rx_clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYC) begin
      $display("timeout after %0d cycles with %0d descriptors pending", cycles,
               exp_desc.size());
      $display("errors: %0d scoreboard, %0d property", errors, u_dut.u_props.fail_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ====================
  // test sequence
  // ====================
  initial begin
    rstn_mac = 1'b0;
    rx_dv    = 1'b0;
    rx_d     = 8'h00;
    void'($urandom(SEED));
    repeat (2) @(posedge rx_clk);
    #1 rstn_mac = 1'b1;
    repeat (3) @(posedge rx_clk);

    make_frame(100, 1'b0);
    run_frame("be_frame", 1'b1, 16);
    make_frame(100, 1'b1);
    run_frame("tte_tag", 1'b1, 16);
    frm[gmii_rx_pkg::TTE_TAG_IDX] = 8'h91;    // same frame with another tag
    refresh_fcs();
    run_frame("tag_changed", 1'b1, 16);
    make_frame(100, 1'b0);
    frm[40] ^= 8'h04;                         // bit flip after the FCS
    run_frame("bad_crc", 1'b1, 16);
    make_frame(60, 1'b0);
    run_frame("runt", 1'b1, 16);
    make_frame(1530, 1'b0);
    run_frame("oversize", 1'b1, 16);
    make_junk(20);
    run_frame("no_sfd", 1'b0, 16);
    make_frame(10, 1'b0);
    run_frame("short", 1'b1, 16);
    make_frame(80, 1'b1);
    run_frame("b2b_first", 1'b1, 12);
    make_frame(72, 1'b0);
    run_frame("b2b_second", 1'b1, 16);

    while (exp_desc.size() != 0) begin
      @(posedge rx_clk);
    end
    repeat (20) @(posedge rx_clk);  // catch late strays
    if (exp_bytes.size() != 0) begin
      $display("%0d expected bytes never arrived", exp_bytes.size());
      errors++;
    end
    $display("errors: %0d scoreboard, %0d property", errors, u_dut.u_props.fail_cnt);
    if (errors == 0 && u_dut.u_props.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
